//--- Makefile
# Verilator simulation of the MAC unit

VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_mac
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
+incdir+source
source/mac_pkg.sv
source/operand_receiver.sv
source/operand_fifo.sv
source/math_mult_18.sv
source/mac_engine.sv
source/result_sender.sv
source/mac_top.sv
testbench/mac_props.sv
testbench/tb_mac.sv

//--- source/mac_engine.sv
////////////////////////////////////////////////////////////////////////////
// MAC engine
// pops commands into the multiplier and accumulates products by opcode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module mac_engine (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire mac_pkg::mac_cmd_t pop_data,
  input  wire logic              empty,
  output logic                   pop,
  output logic                   res_valid,
  output mac_pkg::mac_result_t   res_data,
  input  wire logic              res_busy
);

  import mac_pkg::*;

  logic                          ena;
  logic signed [`MAC_PROD_W-1:0] prod;
  logic signed [`MAC_ACC_W-1:0]  prod_ext;
  logic signed [`MAC_ACC_W-1:0]  acc;
  logic [2:0]                    vld_pipe;
  mac_op_e                       op_pipe [3];
  mac_op_e                       res_op;

  // whole pipeline stalls while a result waits on the sender
  assign ena = !(res_valid && res_busy);
  assign pop = !empty && ena;

  math_mult_18 u_mult (
    .clk    (clk),
    .arst_n (arst_n),
    .ena    (ena),
    .dina   (pop_data.dina),
    .dinb   (pop_data.dinb),
    .dout   (prod)
  );

  assign prod_ext = {{(`MAC_ACC_W - `MAC_PROD_W){prod[`MAC_PROD_W-1]}}, prod};

  ////////////////////////////////////////////////////////////////////////////
  // shadow pipeline, one slot per multiplier stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld_pipe  <= '0;
      res_valid <= 1'b0;
      acc       <= '0;
    end else if (ena) begin
      vld_pipe  <= {vld_pipe[1:0], pop};
      res_valid <= vld_pipe[2];
      if (vld_pipe[2]) begin
        // mul restarts the sum, mac adds onto it
        acc <= (op_pipe[2] == OP_MUL) ? prod_ext : acc + prod_ext;
      end
    end
  end

  // opcode travels beside the product
  always_ff @(posedge clk) begin
    if (ena) begin
      op_pipe[0] <= pop_data.op;
      op_pipe[1] <= op_pipe[0];
      op_pipe[2] <= op_pipe[1];
      res_op     <= op_pipe[2];
    end
  end

  assign res_data = '{op: res_op, acc: acc};

endmodule

`default_nettype wire

//--- source/mac_pkg.sv
////////////////////////////////////////////////////////////////////////////
// mac package
// opcode, command and result types, handshake states
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "mac_settings.svh"

package mac_pkg;

  // opcodes
  typedef enum logic {
    OP_MUL = 1'b0,
    OP_MAC = 1'b1
  } mac_op_e;

  // command as seen on the input port and in the FIFO
  typedef struct packed {
    mac_op_e                       op;
    logic signed [`MAC_DINA_W-1:0] dina;
    logic signed [`MAC_DINB_W-1:0] dinb;
  } mac_cmd_t;

  // result as returned on the output port
  typedef struct packed {
    mac_op_e                      op;
    logic signed [`MAC_ACC_W-1:0] acc;
  } mac_result_t;

  // four-phase handshake states, shared by receiver and sender
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    WAIT_DROP    = 2'd1,
    WAIT_ACK_LOW = 2'd2
  } hs_state_e;

endpackage

`default_nettype wire

//--- source/mac_settings.svh
////////////////////////////////////////////////////////////////////////////
// mac settings
// operand, product and accumulator widths plus operand FIFO depth
////////////////////////////////////////////////////////////////////////////

`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// multiplier operand widths, signed
`define MAC_DINA_W 25
`define MAC_DINB_W 18

// full product of a and b
`define MAC_PROD_W 43

// accumulator and result width
`define MAC_ACC_W 48

// command entries held between receiver and engine
`define MAC_FIFO_DEPTH 4

`endif

//--- source/mac_top.sv
////////////////////////////////////////////////////////////////////////////
// MAC unit top level
// receiver, operand FIFO, engine and result sender
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mac_top (
  input  wire logic                 clk,
  input  wire logic                 arst_n,

  // command port
  input  wire logic                 cmd_req,
  input  wire mac_pkg::mac_cmd_t    cmd,
  output logic                      cmd_ack,

  // result port
  output logic                      res_req,
  output mac_pkg::mac_result_t      res,
  input  wire logic                 res_ack
);

  import mac_pkg::*;

  // receiver to FIFO
  logic        push;
  mac_cmd_t    push_data;
  logic        full;

  // FIFO to engine
  logic        pop;
  mac_cmd_t    pop_data;
  logic        empty;

  // engine to sender
  logic        res_valid;
  mac_result_t res_data;
  logic        res_busy;

  operand_receiver u_receiver (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_req   (cmd_req),
    .cmd       (cmd),
    .cmd_ack   (cmd_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  operand_fifo u_fifo (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_data (push_data),
    .full      (full),
    .pop       (pop),
    .pop_data  (pop_data),
    .empty     (empty)
  );

  mac_engine u_engine (
    .clk       (clk),
    .arst_n    (arst_n),
    .pop_data  (pop_data),
    .empty     (empty),
    .pop       (pop),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_busy  (res_busy)
  );

  result_sender u_sender (
    .clk       (clk),
    .arst_n    (arst_n),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_busy  (res_busy),
    .res_req   (res_req),
    .res       (res),
    .res_ack   (res_ack)
  );

endmodule

`default_nettype wire

//--- source/math_mult_18.sv
////////////////////////////////////////////////////////////////////////////
// single 25x18 signed multiplier
// clock enable, 3 cycles latency, registered output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module math_mult_18 (
  input  wire logic                          clk,
  input  wire logic                          arst_n,
  input  wire logic                          ena,

  // input operands
  input  wire logic signed [`MAC_DINA_W-1:0] dina,
  input  wire logic signed [`MAC_DINB_W-1:0] dinb,

  // product
  output logic signed [`MAC_PROD_W-1:0]      dout
);

  logic signed [`MAC_DINA_W-1:0] a_r;
  logic signed [`MAC_DINB_W-1:0] b_r;
  logic signed [`MAC_PROD_W-1:0] m_r;
  logic signed [`MAC_PROD_W-1:0] p_r;

  ////////////////////////////////////////////////////////////////////////////
  // A/B, M and P stages, all held while ena is low
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      a_r <= '0;
      b_r <= '0;
      m_r <= '0;
      p_r <= '0;
    end else if (ena) begin
      a_r <= dina;
      b_r <= dinb;
      // 25 + 18 bits, no growth beyond the product width
      m_r <= a_r * b_r;
      p_r <= m_r;
    end
  end

  assign dout = p_r;

endmodule

`default_nettype wire

//--- source/operand_fifo.sv
////////////////////////////////////////////////////////////////////////////
// operand FIFO
// circular command buffer, registered entries, no fall-through
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module operand_fifo (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              push,
  input  wire mac_pkg::mac_cmd_t push_data,
  output logic                   full,
  input  wire logic              pop,
  output mac_pkg::mac_cmd_t      pop_data,
  output logic                   empty
);

  import mac_pkg::*;

  localparam int PTR_W = $clog2(`MAC_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`MAC_FIFO_DEPTH + 1);

  mac_cmd_t         mem [`MAC_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full     = (count == CNT_W'(`MAC_FIFO_DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`MAC_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`MAC_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/operand_receiver.sv
////////////////////////////////////////////////////////////////////////////
// operand receiver
// four-phase req/ack slave, writes each command once into the FIFO
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module operand_receiver (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              cmd_req,
  input  wire mac_pkg::mac_cmd_t cmd,
  output logic                   cmd_ack,
  input  wire logic              full,
  output logic                   push,
  output mac_pkg::mac_cmd_t      push_data
);

  import mac_pkg::*;

  hs_state_e state;
  logic      req_sync;
  logic      load;

  // new request seen, nothing pending, room in the FIFO
  assign load = (state == IDLE) && req_sync && !push && !full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_sync <= 1'b0;
      state    <= IDLE;
      push     <= 1'b0;
      cmd_ack  <= 1'b0;
    end else begin
      req_sync <= cmd_req;
      case (state)
        IDLE: begin
          if (load) begin
            push <= 1'b1;
          end else if (push && !full) begin
            // write taken this cycle, acknowledge afterwards
            push    <= 1'b0;
            cmd_ack <= 1'b1;
            state   <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!req_sync) begin
            cmd_ack <= 1'b0;
            state   <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // command is stable while cmd_req is high
  always_ff @(posedge clk) begin
    if (load) begin
      push_data <= cmd;
    end
  end

endmodule

`default_nettype wire

//--- source/result_sender.sv
////////////////////////////////////////////////////////////////////////////
// result sender
// four-phase req/ack master, one result held until acknowledged
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module result_sender (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 res_valid,
  input  wire mac_pkg::mac_result_t res_data,
  output logic                      res_busy,
  output logic                      res_req,
  output mac_pkg::mac_result_t      res,
  input  wire logic                 res_ack
);

  import mac_pkg::*;

  hs_state_e state;
  logic      ack_sync;
  logic      accept;

  assign res_busy = (state != IDLE);
  assign accept   = res_valid && !res_busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack_sync <= 1'b0;
      state    <= IDLE;
      res_req  <= 1'b0;
    end else begin
      ack_sync <= res_ack;
      case (state)
        IDLE: begin
          if (accept) begin
            res_req <= 1'b1;
            state   <= WAIT_DROP;
          end
        end
        // req up, wait for the sink to answer
        WAIT_DROP: begin
          if (ack_sync) begin
            res_req <= 1'b0;
            state   <= WAIT_ACK_LOW;
          end
        end
        WAIT_ACK_LOW: begin
          if (!ack_sync) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res <= res_data;
    end
  end

endmodule

`default_nettype wire

//--- testbench/mac_props.sv
////////////////////////////////////////////////////////////////////////////
// MAC port checks
// four-phase rules on the command and result ports of the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module mac_props (
  input wire logic                 clk,
  input wire logic                 arst_n,
  input wire logic                 cmd_req,
  input wire mac_pkg::mac_cmd_t    cmd,
  input wire logic                 cmd_ack,
  input wire logic                 res_req,
  input wire mac_pkg::mac_result_t res,
  input wire logic                 res_ack
);

  // number of failed assertions so far
  int failures = 0;

  // ack only answers a live request
  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(cmd_ack) |-> cmd_req)
    else begin
      failures++;
      $error("cmd_ack rose while cmd_req was low");
    end

  // source holds request and command until acknowledged
  cmd_held: assert property (@(posedge clk) disable iff (!arst_n)
    cmd_req && !cmd_ack |=> cmd_req && $stable(cmd))
    else begin
      failures++;
      $error("cmd_req or cmd changed before cmd_ack");
    end

  res_held: assert property (@(posedge clk) disable iff (!arst_n)
    res_req && !res_ack |=> res_req && $stable(res))
    else begin
      failures++;
      $error("res_req or res changed before res_ack");
    end

  // new result only after the sink has dropped its ack
  req_after_ack_low: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(res_req) |-> !res_ack)
    else begin
      failures++;
      $error("res_req rose while res_ack was high");
    end

endmodule

bind mac_top mac_props u_props (.*);

`default_nettype wire

//--- testbench/tb_mac.sv
////////////////////////////////////////////////////////////////////////////
// MAC unit testbench
// directed tests on both four-phase ports against an accumulator model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "mac_settings.svh"

module tb_mac;

  import mac_pkg::*;

  // about 250 operations at 8 to 37 cycles each come to roughly 3000
  localparam int timeout_cycles = 4000;

  logic        clk;
  logic        arst_n;
  logic        cmd_req;
  mac_cmd_t    cmd;
  logic        cmd_ack;
  logic        res_req;
  mac_result_t res;
  logic        res_ack;

  logic signed [`MAC_ACC_W-1:0] model_acc;
  mac_result_t                  expected [$];
  mac_cmd_t                     batch [$];
  integer                       seed = 32'h4692;
  int                           cycles = 0;
  int                           full_cycles = 0;
  int                           checks = 0;
  int                           errors = 0;
  int                           tests = 0;
  int                           err_mark;
  int                           ack_delay = 0;
  bit                           rand_delay = 1'b0;

  mac_top u_dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .res_req (res_req),
    .res     (res),
    .res_ack (res_ack)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (u_dut.full) begin
      full_cycles <= full_cycles + 1;
    end
    if (cycles >= timeout_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // reference accumulator where mul reloads and mac adds
  task automatic model(input mac_cmd_t c);
    logic signed [`MAC_ACC_W-1:0] a;
    logic signed [`MAC_ACC_W-1:0] b;
    mac_result_t                  r;
    a = c.dina;
    b = c.dinb;
    if (c.op == OP_MUL) begin
      model_acc = a * b;
    end else begin
      model_acc = model_acc + a * b;
    end
    r.op  = c.op;
    r.acc = model_acc;
    expected.push_back(r);
  endtask

  function automatic mac_cmd_t make_cmd(input mac_op_e op, input int a, input int b);
    mac_cmd_t c;
    c.op   = op;
    c.dina = a[`MAC_DINA_W-1:0];
    c.dinb = b[`MAC_DINB_W-1:0];
    return c;
  endfunction

  // source side of the command handshake
  task automatic send(input mac_cmd_t c);
    model(c);
    cmd     <= c;
    cmd_req <= 1'b1;
    do @(posedge clk); while (!cmd_ack);
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
  endtask

  // sink side with the ack held back by the programmed delay
  task automatic receive(input int n);
    mac_result_t exp;
    int          d;
    repeat (n) begin
      do @(posedge clk); while (!res_req);
      if (expected.size() == 0) begin
        errors++;
        $display("a result arrived with no command outstanding");
      end else begin
        exp = expected.pop_front();
        compare("res.op", res.op, exp.op);
        compare("res.acc", res.acc, exp.acc);
      end
      d = rand_delay ? int'($unsigned($random(seed)) % 8) : ack_delay;
      repeat (d) @(posedge clk);
      res_ack <= 1'b1;
      do @(posedge clk); while (res_req);
      res_ack <= 1'b0;
    end
  endtask

  task automatic run_batch();
    fork
      foreach (batch[i]) send(batch[i]);
      receive(batch.size());
    join
    batch.delete();
  endtask

  // both handshake outputs stay low for n cycles
  task automatic check_quiet(input int n);
    repeat (n) begin
      @(posedge clk);
      compare("cmd_ack", cmd_ack, 1'b0);
      compare("res_req", res_req, 1'b0);
    end
  endtask

  task automatic start_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-16s finished with %0d errors", name, errors - err_mark);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_quiet();
    start_test();
    check_quiet(20);
    end_test("reset");
  endtask

  task automatic single_multiply();
    start_test();
    batch.push_back(make_cmd(OP_MUL, 3, 5));
    batch.push_back(make_cmd(OP_MUL, -7, 11));
    batch.push_back(make_cmd(OP_MUL, -1000, -2000));
    batch.push_back(make_cmd(OP_MUL, 12345, -678));
    batch.push_back(make_cmd(OP_MUL, 0, 99));
    run_batch();
    end_test("single_multiply");
  endtask

  task automatic accumulate_chain();
    start_test();
    batch.push_back(make_cmd(OP_MUL, 10, 10));
    for (int i = 1; i <= 6; i++) begin
      batch.push_back(make_cmd(OP_MAC, i * 1001, -(i * 37)));
    end
    // sum restarts here
    batch.push_back(make_cmd(OP_MUL, -4096, 3));
    batch.push_back(make_cmd(OP_MAC, 500, 500));
    batch.push_back(make_cmd(OP_MAC, -250, 4));
    run_batch();
    end_test("accumulate_chain");
  endtask

  task automatic back_pressure();
    int mark;
    start_test();
    mark      = full_cycles;
    ack_delay = 30;
    for (int i = 0; i < 14; i++) begin
      batch.push_back(make_cmd(i % 3 == 0 ? OP_MUL : OP_MAC, $random(seed), $random(seed)));
    end
    run_batch();
    ack_delay = 0;
    // no result repeated after the last one
    check_quiet(20);
    if (full_cycles == mark) begin
      errors++;
      $display("the FIFO never filled while results were held back");
    end
    end_test("back_pressure");
  endtask

  task automatic extremes();
    int a_min;
    int a_max;
    int b_min;
    int b_max;
    start_test();
    a_min = -(1 << (`MAC_DINA_W - 1));
    a_max = (1 << (`MAC_DINA_W - 1)) - 1;
    b_min = -(1 << (`MAC_DINB_W - 1));
    b_max = (1 << (`MAC_DINB_W - 1)) - 1;
    batch.push_back(make_cmd(OP_MUL, a_max, b_max));
    batch.push_back(make_cmd(OP_MUL, a_min, b_max));
    batch.push_back(make_cmd(OP_MUL, a_max, b_min));
    batch.push_back(make_cmd(OP_MUL, a_min, b_min));
    // each term is 2^41 so the 48-bit signed sum wraps after 64 of them
    repeat (68) batch.push_back(make_cmd(OP_MAC, a_min, b_min));
    run_batch();
    end_test("extremes");
  endtask

  task automatic random_stream();
    mac_op_e op;
    start_test();
    rand_delay = 1'b1;
    repeat (150) begin
      op = ($random(seed) & 1) ? OP_MAC : OP_MUL;
      batch.push_back(make_cmd(op, $random(seed), $random(seed)));
    end
    run_batch();
    rand_delay = 1'b0;
    end_test("random_stream");
  endtask

  initial begin
    cmd_req   <= 1'b0;
    cmd       <= '0;
    res_ack   <= 1'b0;
    arst_n    <= 1'b0;
    model_acc = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    reset_quiet();
    single_multiply();
    accumulate_chain();
    back_pressure();
    extremes();
    random_stream();
    if (u_dut.u_props.failures != 0) begin
      errors += u_dut.u_props.failures;
      $display("%0d handshake assertions failed on the ports", u_dut.u_props.failures);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
